//--- hw/id_pkg.sv
`default_nettype none

package id_pkg;

    localparam int NB_INST     = 32;        // Instruction word
    localparam int NB_DATA     = 32;        // Register data
    localparam int NB_PC       = 32;
    localparam int NB_REG      = 5;         // Register index
    localparam int NB_OPCODE   = 6;
    localparam int NB_FUNCT    = 6;
    localparam int NB_ALU_OP   = 4;
    localparam int NB_IMM      = 16;        // I-type immediate
    localparam int NB_TARGET   = 26;        // J-type target
    localparam int NB_PC_UPPER = 4;         // PC bits kept by a jump
    localparam int N_REGS      = 32;

    typedef enum logic [NB_OPCODE-1:0] {
        R_TYPE = 6'b000000,
        J      = 6'b000010,
        JAL    = 6'b000011,
        BEQ    = 6'b000100,
        BNE    = 6'b000101,
        ADDI   = 6'b001000,
        SLTI   = 6'b001010,
        ANDI   = 6'b001100,
        ORI    = 6'b001101,
        XORI   = 6'b001110,
        LUI    = 6'b001111,
        LB     = 6'b100000,
        LH     = 6'b100001,
        LW     = 6'b100011,
        SB     = 6'b101000,
        SH     = 6'b101001,
        SW     = 6'b101011,
        HALT   = 6'b111111
    } opcode_e;

    typedef enum logic [NB_FUNCT-1:0] {
        SLL  = 6'b000000,
        SRL  = 6'b000010,
        SRA  = 6'b000011,
        JR   = 6'b001000,
        JALR = 6'b001001,
        ADD  = 6'b100000,
        SUB  = 6'b100010,
        AND  = 6'b100100,
        OR   = 6'b100101,
        XOR  = 6'b100110,
        NOR  = 6'b100111,
        SLT  = 6'b101010
    } funct_e;

    // Resolved operation for the execute stage
    typedef enum logic [NB_ALU_OP-1:0] {
        ALU_ADD = 4'd0,                     // Zero so a bubble is all zero
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_XOR = 4'd4,
        ALU_NOR = 4'd5,
        ALU_SLT = 4'd6,
        ALU_SLL = 4'd7,
        ALU_SRL = 4'd8,
        ALU_SRA = 4'd9,
        ALU_LUI = 4'd10
    } alu_op_e;

    typedef struct packed {
        logic    reg_dest;                  // rd instead of rt in EX
        alu_op_e alu_op;                    // EX
        logic    alu_src;                   // Immediate operand in EX
        logic    mem_read;                  // MEM
        logic    mem_write;                 // MEM
        logic    branch;                    // MEM
        logic    reg_write;                 // WB
        logic    mem_to_reg;                // WB
        logic    jump;
        logic    byte_en;
        logic    halfword_en;
        logic    word_en;
        logic    jr_jalr;                   // Target from rs in IF
        logic    hlt;
    } ctrl_t;

    typedef struct packed {
        opcode_e             opcode;
        logic [NB_REG-1:0]   rs;
        logic [NB_REG-1:0]   rt;
        logic [NB_REG-1:0]   rd;
        logic [NB_REG-1:0]   shamt;
        funct_e              funct;
    } inst_fields_t;

endpackage

`default_nettype wire

//--- hw/register_bank.sv
`timescale 1ns/1ps
`default_nettype none

module register_bank import id_pkg::*; (
    input  wire                 i_clock,
    input  wire                 i_arst_n,
    input  wire                 i_enable,           // Debug unit write gate
    input  wire                 i_reg_write,        // From WB
    input  wire  [NB_REG-1:0]   i_read_reg_a,
    input  wire  [NB_REG-1:0]   i_read_reg_b,
    input  wire  [NB_REG-1:0]   i_read_address,     // Debug unit
    input  wire  [NB_REG-1:0]   i_write_reg,
    input  wire  [NB_DATA-1:0]  i_write_data,
    output logic [NB_DATA-1:0]  o_data_a,
    output logic [NB_DATA-1:0]  o_data_b,
    output logic [NB_DATA-1:0]  o_debug_data
);

    // r0 has no storage
    logic [NB_DATA-1:0] regs [1:N_REGS-1];
    logic               write_en;

    assign write_en = i_enable && i_reg_write && (i_write_reg != '0);

    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            for (int i = 1; i < N_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (write_en) begin
            regs[i_write_reg] <= i_write_data;
        end
    end

    // Plain reads with no write bypass
    always_comb begin
        o_data_a     = '0;
        o_data_b     = '0;
        o_debug_data = '0;
        if (i_read_reg_a != '0) begin
            o_data_a = regs[i_read_reg_a];
        end
        if (i_read_reg_b != '0) begin
            o_data_b = regs[i_read_reg_b];
        end
        if (i_read_address != '0) begin
            o_debug_data = regs[i_read_address];
        end
    end

endmodule

`default_nettype wire

//--- hw/control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module control_unit import id_pkg::*; (
    input  wire          i_clock,
    input  wire          i_arst_n,
    input  wire          i_enable,          // Low stalls the control word
    input  wire opcode_e i_opcode,
    input  wire funct_e  i_funct,
    output ctrl_t        o_ctrl
);

    ctrl_t ctrl_next;

    always_comb begin
        ctrl_next = '0;                     // Bubble unless decoded
        case (i_opcode)
            R_TYPE: begin
                ctrl_next.reg_dest  = 1'b1;
                ctrl_next.reg_write = 1'b1;
                case (i_funct)
                    SLL:  ctrl_next.alu_op = ALU_SLL;
                    SRL:  ctrl_next.alu_op = ALU_SRL;
                    SRA:  ctrl_next.alu_op = ALU_SRA;
                    ADD:  ctrl_next.alu_op = ALU_ADD;
                    SUB:  ctrl_next.alu_op = ALU_SUB;
                    AND:  ctrl_next.alu_op = ALU_AND;
                    OR:   ctrl_next.alu_op = ALU_OR;
                    XOR:  ctrl_next.alu_op = ALU_XOR;
                    NOR:  ctrl_next.alu_op = ALU_NOR;
                    SLT:  ctrl_next.alu_op = ALU_SLT;
                    JR: begin
                        ctrl_next.jr_jalr   = 1'b1;
                        ctrl_next.reg_write = 1'b0;   // No link
                    end
                    JALR: begin
                        ctrl_next.jr_jalr   = 1'b1;   // Links into rd
                    end
                    default: begin
                        ctrl_next = '0;               // Unknown funct
                    end
                endcase
            end

            J: begin
                ctrl_next.jump = 1'b1;
            end

            JAL: begin
                ctrl_next.jump      = 1'b1;
                ctrl_next.reg_write = 1'b1;           // Link into r31
            end

            BEQ, BNE: begin
                ctrl_next.branch = 1'b1;
                ctrl_next.alu_op = ALU_SUB;           // Compare by subtraction
            end

            ADDI, ANDI, ORI, XORI, LUI, SLTI: begin
                ctrl_next.alu_src   = 1'b1;
                ctrl_next.reg_write = 1'b1;
                case (i_opcode)
                    ANDI:    ctrl_next.alu_op = ALU_AND;
                    ORI:     ctrl_next.alu_op = ALU_OR;
                    XORI:    ctrl_next.alu_op = ALU_XOR;
                    LUI:     ctrl_next.alu_op = ALU_LUI;
                    SLTI:    ctrl_next.alu_op = ALU_SLT;
                    default: ctrl_next.alu_op = ALU_ADD;
                endcase
            end

            LB, LH, LW: begin
                ctrl_next.mem_read    = 1'b1;
                ctrl_next.mem_to_reg  = 1'b1;
                ctrl_next.alu_src     = 1'b1;         // Base plus offset
                ctrl_next.reg_write   = 1'b1;
                ctrl_next.byte_en     = (i_opcode == LB);
                ctrl_next.halfword_en = (i_opcode == LH);
                ctrl_next.word_en     = (i_opcode == LW);
            end

            SB, SH, SW: begin
                ctrl_next.mem_write   = 1'b1;
                ctrl_next.alu_src     = 1'b1;
                ctrl_next.byte_en     = (i_opcode == SB);
                ctrl_next.halfword_en = (i_opcode == SH);
                ctrl_next.word_en     = (i_opcode == SW);
            end

            HALT: begin
                ctrl_next.hlt = 1'b1;
            end

            default: begin
                ctrl_next = '0;                       // Unknown opcode
            end
        endcase
    end

    // Registered for EX and held while stalled
    always_ff @(posedge i_clock or negedge i_arst_n) begin
        if (!i_arst_n) begin
            o_ctrl <= '0;
        end else if (i_enable) begin
            o_ctrl <= ctrl_next;
        end
    end

endmodule

`default_nettype wire

//--- hw/immediate_unit.sv
`timescale 1ns/1ps
`default_nettype none

module immediate_unit import id_pkg::*; (
    input  wire  [NB_IMM-1:0]       i_imm16,
    input  wire  [NB_REG-1:0]       i_shamt,
    input  wire  [NB_TARGET-1:0]    i_target26,
    input  wire  [NB_PC_UPPER-1:0]  i_pc_upper,     // PC[31:28]
    output logic [NB_DATA-1:0]      o_immediate,
    output logic [NB_DATA-1:0]      o_shamt,
    output logic [NB_PC-1:0]        o_jump_address
);

    logic imm_sign;

    assign imm_sign = i_imm16[NB_IMM-1];

    // Sign extended offset or operand
    assign o_immediate = {{(NB_DATA-NB_IMM){imm_sign}}, i_imm16};

    // Shift amount is unsigned
    assign o_shamt = {{(NB_DATA-NB_REG){1'b0}}, i_shamt};

    // Word aligned target inside the current 256 MB region
    assign o_jump_address = {i_pc_upper, i_target26, 2'b00};

endmodule

`default_nettype wire

//--- hw/id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage import id_pkg::*; (
    input  wire                 i_clock,
    input  wire                 i_arst_n,
    input  wire                 i_cu_enable,        // Debug unit
    input  wire                 i_rb_enable,        // Debug unit
    input  wire  [NB_REG-1:0]   i_rb_read_address,  // Debug unit
    input  wire  [NB_INST-1:0]  i_inst,
    input  wire  [NB_PC-1:0]    i_pc,
    input  wire                 i_wb_reg_write,     // From WB
    input  wire  [NB_REG-1:0]   i_wb_write_reg,     // From WB
    input  wire  [NB_DATA-1:0]  i_wb_write_data,    // From WB
    output ctrl_t               o_ctrl,             // To EX, MEM and WB
    output logic [NB_DATA-1:0]  o_data_a,
    output logic [NB_DATA-1:0]  o_data_b,
    output logic [NB_DATA-1:0]  o_immediate,
    output logic [NB_DATA-1:0]  o_shamt,
    output logic [NB_PC-1:0]    o_jump_address,
    output logic [NB_REG-1:0]   o_rt,
    output logic [NB_REG-1:0]   o_rd,
    output logic [NB_PC-1:0]    o_pc,
    output logic [NB_DATA-1:0]  o_debug_data
);

    inst_fields_t inst;

    assign inst = i_inst;

    register_bank u_register_bank (
        .i_clock        (i_clock),
        .i_arst_n       (i_arst_n),
        .i_enable       (i_rb_enable),
        .i_reg_write    (i_wb_reg_write),
        .i_read_reg_a   (inst.rs),
        .i_read_reg_b   (inst.rt),
        .i_read_address (i_rb_read_address),
        .i_write_reg    (i_wb_write_reg),
        .i_write_data   (i_wb_write_data),
        .o_data_a       (o_data_a),
        .o_data_b       (o_data_b),
        .o_debug_data   (o_debug_data)
    );

    control_unit u_control_unit (
        .i_clock  (i_clock),
        .i_arst_n (i_arst_n),
        .i_enable (i_cu_enable),
        .i_opcode (inst.opcode),
        .i_funct  (inst.funct),
        .o_ctrl   (o_ctrl)
    );

    immediate_unit u_immediate_unit (
        .i_imm16        (i_inst[NB_IMM-1:0]),
        .i_shamt        (inst.shamt),
        .i_target26     (i_inst[NB_TARGET-1:0]),
        .i_pc_upper     (i_pc[NB_PC-1 -: NB_PC_UPPER]),
        .o_immediate    (o_immediate),
        .o_shamt        (o_shamt),
        .o_jump_address (o_jump_address)
    );

    // Destination candidates for the EX mux
    assign o_rt = inst.rt;
    assign o_rd = inst.rd;
    assign o_pc = i_pc;

endmodule

`default_nettype wire

//--- test/id_stage_checker.sv
`timescale 1ns/1ps
`default_nettype none

module id_stage_checker import id_pkg::*; (
    input wire                i_clock,
    input wire                i_arst_n,
    input wire                i_cu_enable,
    input wire [NB_INST-1:0]  i_inst,
    input wire ctrl_t         i_ctrl,
    input wire [NB_DATA-1:0]  i_data_a
);

    inst_fields_t fields;

    assign fields = i_inst;

    a_reset_bubble: assert property (@(posedge i_clock) !i_arst_n |-> i_ctrl == '0)
        else $error("o_ctrl is not zero during reset");

    // Stalled edge keeps the word
    a_stall_hold: assert property (@(posedge i_clock) disable iff (!i_arst_n)
        !i_cu_enable |=> $stable(i_ctrl))
        else $error("o_ctrl changed after a stalled cycle");

    a_r0_zero: assert property (@(posedge i_clock) fields.rs == '0 |-> i_data_a == '0)
        else $error("o_data_a is not zero for rs 0");

endmodule

bind id_stage id_stage_checker i_checker (
    .i_clock     (i_clock),
    .i_arst_n    (i_arst_n),
    .i_cu_enable (i_cu_enable),
    .i_inst      (i_inst),
    .i_ctrl      (o_ctrl),
    .i_data_a    (o_data_a)
);

`default_nettype wire

//--- test/tb_id_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_id_stage import id_pkg::*; ();

    logic               i_clock, i_arst_n, i_cu_enable, i_rb_enable, i_wb_reg_write;
    logic [NB_REG-1:0]  i_rb_read_address, i_wb_write_reg, o_rt, o_rd;
    logic [NB_INST-1:0] i_inst;
    logic [NB_PC-1:0]   i_pc, o_jump_address, o_pc;
    logic [NB_DATA-1:0] i_wb_write_data, o_data_a, o_data_b;
    logic [NB_DATA-1:0] o_immediate, o_shamt, o_debug_data;
    ctrl_t              o_ctrl;
    logic [NB_DATA-1:0] model [N_REGS] = '{default: '0};   // Expected bank contents
    logic [31:0]        lcg_state = 32'h3af;
    int                 n_mismatch = 0;
    int                 n_other = 0;

    id_stage i_dut (.*);

    always #2 i_clock = ~i_clock;                           // 4 ns period

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    task automatic wait_falling(input longint n);
        longint start;
        longint seen;
        start = $time;
        seen = 0;
        while (seen < n) begin
            @(negedge i_clock);
            seen++;
            if ($time - start > 4 * n + 40) begin
                $display("error: timed out waiting for %0d falling edges", n);
                n_other++;
                seen = n;
            end
        end
    endtask

    task automatic compare_ctrl(input string name, input ctrl_t got, input ctrl_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            n_mismatch++;
        end
    endtask

    task automatic compare_data(input string name, input logic [NB_DATA-1:0] got, exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            n_mismatch++;
        end
    endtask

    task automatic compare_reg(input string name, input logic [NB_REG-1:0] got, exp);
        if (got !== exp) begin
            $display("mismatch %s: got %h, expected %h", name, got, exp);
            n_mismatch++;
        end
    endtask

    function automatic ctrl_t expected_ctrl(input logic [5:0] op, input logic [5:0] fn);
        ctrl_t c;
        c = '0;
        case (op)
            R_TYPE: begin
                c.reg_dest  = 1'b1;
                c.reg_write = (fn != JR);                   // JR has no link
                c.jr_jalr   = (fn == JR) || (fn == JALR);
                case (fn)
                    SLL: c.alu_op = ALU_SLL;
                    SRL: c.alu_op = ALU_SRL;
                    SRA: c.alu_op = ALU_SRA;
                    SUB: c.alu_op = ALU_SUB;
                    AND: c.alu_op = ALU_AND;
                    OR:  c.alu_op = ALU_OR;
                    XOR: c.alu_op = ALU_XOR;
                    NOR: c.alu_op = ALU_NOR;
                    SLT: c.alu_op = ALU_SLT;
                    default: c.alu_op = ALU_ADD;
                endcase
            end
            ADDI, ANDI, ORI, XORI, LUI, SLTI: begin
                c.alu_src   = 1'b1;
                c.reg_write = 1'b1;
                case (op)
                    ANDI: c.alu_op = ALU_AND;
                    ORI:  c.alu_op = ALU_OR;
                    XORI: c.alu_op = ALU_XOR;
                    LUI:  c.alu_op = ALU_LUI;
                    SLTI: c.alu_op = ALU_SLT;
                    default: c.alu_op = ALU_ADD;
                endcase
            end
            LB, LH, LW, SB, SH, SW: begin
                c.mem_read    = (op == LB) || (op == LH) || (op == LW);
                c.mem_write   = !c.mem_read;
                c.mem_to_reg  = c.mem_read;
                c.reg_write   = c.mem_read;
                c.alu_src     = 1'b1;
                c.byte_en     = (op == LB) || (op == SB);
                c.halfword_en = (op == LH) || (op == SH);
                c.word_en     = (op == LW) || (op == SW);
            end
            BEQ, BNE: begin
                c.branch = 1'b1;
                c.alu_op = ALU_SUB;
            end
            J, JAL: begin
                c.jump      = 1'b1;
                c.reg_write = (op == JAL);
            end
            HALT: c.hlt = 1'b1;
            default: c = '0;
        endcase
        return c;
    endfunction

    // Registered word after one enabled edge
    task automatic apply_inst(input logic [NB_INST-1:0] inst, input ctrl_t exp);
        i_inst = inst;
        wait_falling(1);
        compare_ctrl("o_ctrl", o_ctrl, exp);
    endtask

    task automatic read_all_registers();
        logic [NB_REG-1:0] idx;
        for (int r = 0; r < N_REGS; r++) begin
            idx = r[NB_REG-1:0];
            i_inst = {6'h0, idx, idx, 16'h0};
            i_rb_read_address = idx;
            #1;
            compare_data("o_data_a", o_data_a, model[r]);
            compare_data("o_data_b", o_data_b, model[r]);
            compare_data("o_debug_data", o_debug_data, model[r]);
            wait_falling(1);
        end
    endtask

    task automatic write_registers();
        i_wb_reg_write = 1'b1;
        for (int r = 0; r < N_REGS; r++) begin
            i_wb_write_reg = r[NB_REG-1:0];
            i_wb_write_data = next_random();
            if (r != 0) model[r] = i_wb_write_data;         // r0 keeps zero
            wait_falling(1);
        end
        i_rb_enable = 1'b0;                                 // Bank write blocked
        i_wb_write_reg = 5'd7;
        i_wb_write_data = ~model[7];
        wait_falling(1);
        i_rb_enable = 1'b1;
        i_wb_reg_write = 1'b0;
        read_all_registers();
    endtask

    task automatic decode_all_opcodes();
        opcode_e     op;
        funct_e      fn;
        logic [31:0] rnd;
        i_cu_enable = 1'b1;
        op = op.first();
        do begin
            rnd = next_random();
            if (op == R_TYPE) begin
                fn = fn.first();
                do begin
                    apply_inst({op, rnd[25:6], fn}, expected_ctrl(op, fn));
                    fn = fn.next();
                end while (fn != fn.first());
            end else begin
                apply_inst({op, rnd[25:0]}, expected_ctrl(op, rnd[5:0]));
            end
            op = op.next();
        end while (op != op.first());
        apply_inst({6'b010001, rnd[25:0]}, '0);             // Not an opcode
    endtask

    task automatic stall_control();
        apply_inst({ADDI, 26'h0}, expected_ctrl(ADDI, 6'h0));
        i_cu_enable = 1'b0;
        i_inst = {SW, 26'h0};
        wait_falling(1);
        i_inst = {LW, 26'h0};
        wait_falling(1);
        compare_ctrl("o_ctrl", o_ctrl, expected_ctrl(ADDI, 6'h0));
        i_cu_enable = 1'b1;
        wait_falling(1);
        compare_ctrl("o_ctrl", o_ctrl, expected_ctrl(LW, 6'h0));
    endtask

    task automatic datapath_fields();
        logic [NB_INST-1:0] inst;
        for (int k = 0; k < 24; k++) begin
            inst = next_random();
            i_inst = inst;
            i_pc = next_random();
            #1;
            compare_data("o_immediate", o_immediate, {{16{inst[15]}}, inst[15:0]});
            compare_data("o_shamt", o_shamt, {27'h0, inst[10:6]});
            compare_data("o_jump_address", o_jump_address, {i_pc[31:28], inst[25:0], 2'b00});
            compare_reg("o_rt", o_rt, inst[20:16]);
            compare_reg("o_rd", o_rd, inst[15:11]);
            compare_data("o_pc", o_pc, i_pc);
            wait_falling(1);
        end
    endtask

    task automatic halt_and_jr();
        ctrl_t exp;
        exp = '0;
        exp.hlt = 1'b1;
        apply_inst({HALT, 26'h0}, exp);
        exp = '0;
        exp.reg_dest = 1'b1;
        exp.jr_jalr = 1'b1;
        apply_inst({R_TYPE, 5'd4, 15'h0, JR}, exp);
        exp.reg_write = 1'b1;                               // JALR links
        apply_inst({R_TYPE, 5'd4, 5'd0, 5'd31, 5'd0, JALR}, exp);
    endtask

    initial begin
        i_clock = 1'b0;
        i_arst_n = 1'b0;
        i_cu_enable = 1'b0;
        i_rb_enable = 1'b1;
        i_rb_read_address = '0;
        i_inst = '0;
        i_pc = '0;
        i_wb_reg_write = 1'b0;
        i_wb_write_reg = '0;
        i_wb_write_data = '0;
        wait_falling(16);
        i_arst_n = 1'b1;
        compare_ctrl("o_ctrl", o_ctrl, '0);
        read_all_registers();
        write_registers();
        decode_all_opcodes();
        stall_control();
        datapath_fields();
        halt_and_jr();
        $display("%0d mismatches, %0d other errors", n_mismatch, n_other);
        if (n_mismatch + n_other == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        #20000;
        $display("error: run did not finish within 20 us");
        $display("Simulation FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- compile.f
hw/id_pkg.sv
hw/register_bank.sv
hw/control_unit.sv
hw/immediate_unit.sv
hw/id_stage.sv
test/id_stage_checker.sv
test/tb_id_stage.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build tb_id_stage with Verilator, run it and search the log for a failure
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module tb_id_stage -f compile.f > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }
./obj_dir/Vtb_id_stage > sim.log 2>&1
cat sim.log
grep -q "Simulation FAILED" sim.log && { echo "Test failed"; exit 1; }
grep -q "Simulation PASSED" sim.log || { echo "Test ended without a result"; exit 1; }
echo "Test passed"
